//--- all.f
+incdir+hdl
hdl/corr_cfg_pkg.sv
hdl/corr_frame_pkg.sv
hdl/cmd_parser.sv
hdl/pulse_capture.sv
hdl/coincidence_counter.sv
hdl/frame_packer.sv
hdl/correlator_top.sv
verif/corr_props.sv
verif/tb_correlator.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_correlator -f all.f -o sim_tb &&
out=$(./obj_dir/sim_tb 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "Testbench passed" && echo "run passed" || { echo "run failed"; exit 1; }

//--- verif/tb_correlator.sv
`timescale 1ns/1ps
`include "corr_defs.svh"

module tb_correlator;
	import corr_cfg_pkg::*;

	localparam int N = `CORR_NUM_INPUTS;
	localparam int LA = `CORR_LAG_AUTO;
	localparam int LX = `CORR_LAG_CROSS;
	localparam int NA = `CORR_NUM_AUTO;
	localparam int NUM_COUNTS = N + NA + `CORR_NUM_CROSS;
	localparam int MAX_CYCLES = 20000; // 5 tests x (400 stimulus + 63 bytes x 4) is ~3300

	logic intclk;
	logic rst_n;
	logic [N-1:0] line_in;
	logic [7:0] rx_byte;
	logic rx_strobe;
	logic tx_done;
	logic [7:0] tx_byte;
	logic tx_valid;
	logic integrating;

	logic [N-1:0] line_log [$]; // lines as driven, one entry per cycle
	logic [7:0] exp_bytes [$];
	logic [7:0] got_bytes [$];
	chan_mask_t cur_inv = '0;
	chan_mask_t cur_en = '0;
	int unsigned stim_seed = 47;
	int unsigned frame_pos = 0;
	int unsigned total_bytes = 0;
	int unsigned checked = 0;
	int unsigned total_expected = 0;
	bit slow_tx = 1'b0;
	string test_name = "reset";

	correlator_top dut0 (.*);

	initial begin
		intclk = 1'b0;
		forever #2 intclk = ~intclk;
	end

	function automatic int unsigned lcg(input int unsigned s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// ##################################################
	// reference model

	function automatic void ref_frame(input chan_mask_t inv, input chan_mask_t en);
		logic [N-1:0] pl [$];
		logic [`CORR_RESOLUTION-1:0] cnt [NUM_COUNTS];
		logic hit [NUM_COUNTS];
		logic [7:0] fb [$];
		logic [7:0] csum;
		int p;
		int lag;
		int idx;

		for (int n = 0; n < line_log.size(); n++) begin
			if (n == 0)
				pl.push_back('0);
			else
				pl.push_back((line_log[n] ^ inv) & ~(line_log[n-1] ^ inv) & en);
		end
		for (int x = 0; x < NUM_COUNTS; x++)
			cnt[x] = '0;
		for (int n = 0; n < pl.size(); n++) begin
			for (int x = 0; x < NUM_COUNTS; x++)
				hit[x] = 1'b0;
			p = 0;
			for (int i = 0; i < N; i++) begin
				hit[i] = pl[n][i];
				for (int k = 1; k <= LA; k++)
					if (n >= k) hit[N + i*LA + k-1] = pl[n][i] & pl[n-k][i];
				for (int j = i+1; j < N; j++) begin
					for (int l = 0; l < 2*LX-1; l++) begin
						lag = l - (LX-1);
						idx = N + NA + p*(2*LX-1) + l;
						if (lag >= 0 && n >= lag)
							hit[idx] = pl[n][i] & pl[n-lag][j]; // j earlier
						else if (lag < 0 && n >= -lag)
							hit[idx] = pl[n][j] & pl[n+lag][i]; // roles swapped
					end
					p++;
				end
			end
			for (int x = 0; x < NUM_COUNTS; x++)
				if (hit[x] && cnt[x] != '1) cnt[x] = cnt[x] + 1'b1;
		end
		fb.push_back(`CORR_SYNC_BYTE);
		fb.push_back({4'(LA), 4'(N)});
		for (int x = 0; x < NUM_COUNTS; x++)
			for (int b = `CORR_RESOLUTION/8 - 1; b >= 0; b--)
				fb.push_back(cnt[x][b*8 +: 8]);
		csum = '0;
		foreach (fb[m]) csum ^= fb[m];
		fb.push_back(csum);
		foreach (fb[m]) exp_bytes.push_back(fb[m]);
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
			$display("Testbench failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// ##################################################
	// stimulus

	task automatic tick();
		@(posedge intclk);
		#1;
	endtask

	task automatic drive_lines(input logic [N-1:0] v);
		line_in = v;
		line_log.push_back(v);
		tick();
	endtask

	task automatic send_cmd(input cmd_op_t op, input logic [3:0] arg);
		rx_byte = {op, arg};
		rx_strobe = 1'b1;
		if (op == OP_INVERT) cur_inv = chan_mask_t'(arg);
		if (op == OP_ENABLE) cur_en = chan_mask_t'(arg);
		tick();
		rx_strobe = 1'b0;
		rx_byte = 8'h00;
	endtask

	// mode 0 toggles channel 0 every cycle and mode 1 drives random lines
	task automatic open_window(input int mode, input int ncycles);
		logic [N-1:0] v;
		line_in = '0;
		repeat (4) tick(); // mask changes settle outside the window
		send_cmd(OP_START, 4'h0);
		check_value($sformatf("%s start", test_name), 1, integrating);
		line_log = {};
		repeat (6) drive_lines('0);
		for (int t = 0; t < ncycles; t++) begin
			stim_seed = lcg(stim_seed);
			v = (mode == 0) ? ((t % 2 == 0) ? N'(1) : '0) : N'(stim_seed >> 16);
			drive_lines(v);
		end
		repeat (6) drive_lines('0);
	endtask

	// optionally opens a new window while the frame is still going out
	task automatic close_window(input bit start_midway);
		frame_pos = 0;
		ref_frame(cur_inv, cur_en);
		total_expected += exp_bytes.size();
		send_cmd(OP_STOP, 4'h0);
		check_value($sformatf("%s stop", test_name), 0, integrating);
		if (start_midway) begin
			while (frame_pos < 10) tick();
			send_cmd(OP_START, 4'h0);
			check_value($sformatf("%s restart", test_name), 1, integrating);
		end
		while (exp_bytes.size() != 0 || tx_valid) tick();
	endtask

	// ##################################################
	// line driver, comparator, watchdog

	initial begin : responder
		int unsigned hold;
		int unsigned resp_seed;
		hold = 0;
		resp_seed = 47;
		tx_done = 1'b0;
		forever begin
			tick();
			if (tx_done) begin
				tx_done = 1'b0;
			end else if (tx_valid) begin
				if (hold == 0) begin
					resp_seed = lcg(resp_seed);
					hold = 1 + (resp_seed >> 16) % (slow_tx ? 8 : 3);
				end
				hold--;
				if (hold == 0) begin
					got_bytes.push_back(tx_byte);
					total_bytes++;
					tx_done = 1'b1;
				end
			end
		end
	end

	initial begin : compare
		logic [7:0] actual;
		logic [7:0] expected;
		forever begin
			@(posedge intclk);
			#2;
			while (got_bytes.size() != 0) begin
				actual = got_bytes.pop_front();
				if (exp_bytes.size() == 0) begin
					$display("DUT sent byte %02h while no frame was expected (%s)",
						actual, test_name);
					$display("Testbench failed");
					$fatal(1, "unexpected byte");
				end else begin
					expected = exp_bytes.pop_front();
					check_value($sformatf("%s byte %0d", test_name, frame_pos), expected, actual);
					frame_pos++;
					checked++;
				end
			end
		end
	end

	initial begin : watchdog
		int unsigned cycles;
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge intclk);
			cycles++;
		end
		$display("run did not finish within %0d cycles", MAX_CYCLES);
		$display("Testbench failed");
		$fatal(1, "timeout");
	end

	// ##################################################
	// tests

	initial begin : main
		int unsigned seen;
		rst_n = 1'b0;
		line_in = '0;
		rx_byte = 8'h00;
		rx_strobe = 1'b0;
		repeat (2) @(posedge intclk);
		#1;
		rst_n = 1'b1;
		check_value("reset", 0, {integrating, tx_valid});

		test_name = "t1_single";
		send_cmd(OP_ENABLE, 4'hF);
		open_window(0, 40);
		close_window(1'b0);

		test_name = "t2_random";
		open_window(1, 200);
		close_window(1'b0);

		test_name = "t3_masks";
		send_cmd(OP_INVERT, 4'h3);
		send_cmd(OP_ENABLE, 4'hB); // channel 2 off
		open_window(1, 200);
		close_window(1'b0);
		send_cmd(OP_INVERT, 4'h0);
		send_cmd(OP_ENABLE, 4'hF);

		test_name = "t4_restart";
		open_window(1, 100);
		close_window(1'b0);
		open_window(1, 100); // counts start over
		close_window(1'b0);
		seen = total_bytes;
		send_cmd(OP_STOP, 4'h0);
		repeat (20) tick();
		check_value("t4_stop_idle", seen, total_bytes);

		test_name = "t5_slow";
		slow_tx = 1'b1;
		open_window(1, 150);
		close_window(1'b1);
		line_log = {};
		repeat (6) drive_lines('0); // window from the mid-frame START stays empty
		close_window(1'b0);

		if (checked == total_expected && got_bytes.size() == 0) begin
			$display("Testbench passed");
			$finish;
		end else begin
			$display("only %0d of %0d frame bytes arrived", checked, total_expected);
			$display("Testbench failed");
			$fatal(1, "missing bytes");
		end
	end

endmodule

//--- verif/corr_props.sv
`timescale 1ns/1ps

module corr_props (
	input logic intclk,
	input logic rst_n,
	input logic stop_pulse,
	input logic tx_done,
	input logic tx_valid,
	input logic [7:0] tx_byte
);

	// ##################################################
	// line driver handshake

	hold_until_done: assert property (@(posedge intclk) disable iff (!rst_n)
		tx_valid && !tx_done |=> tx_valid && $stable(tx_byte))
		else $error("tx_byte or tx_valid moved before tx_done");

	reset_idle: assert property (@(posedge intclk) !rst_n |-> !tx_valid)
		else $error("tx_valid high during reset");

	// frames only start from stop_pulse
	start_needs_stop: assert property (@(posedge intclk) disable iff (!rst_n)
		!tx_valid && !stop_pulse |=> !tx_valid)
		else $error("frame started without stop_pulse");

endmodule

bind frame_packer corr_props props0 (
	.intclk     (intclk),
	.rst_n      (rst_n),
	.stop_pulse (stop_pulse),
	.tx_done    (tx_done),
	.tx_valid   (tx_valid),
	.tx_byte    (tx_byte)
);

//--- hdl/correlator_top.sv
`timescale 1ns/1ps
`include "corr_defs.svh"

module correlator_top (
	input  logic intclk,
	input  logic rst_n,
	input  logic [`CORR_NUM_INPUTS-1:0] line_in,
	input  logic [7:0] rx_byte,
	input  logic rx_strobe,
	input  logic tx_done,
	output logic [7:0] tx_byte,
	output logic tx_valid,
	output logic integrating
);
	import corr_cfg_pkg::*;
	import corr_frame_pkg::*;

	chan_mask_t invert_mask;
	chan_mask_t enable_mask;
	chan_mask_t pulses;
	logic start_pulse;
	logic stop_pulse;
	count_t [`CORR_NUM_INPUTS-1:0] chan_counts;
	count_t [`CORR_NUM_AUTO-1:0] auto_counts;
	count_t [`CORR_NUM_CROSS-1:0] cross_counts;

	cmd_parser parser (
		.intclk      (intclk),
		.rst_n       (rst_n),
		.rx_byte     (rx_byte),
		.rx_strobe   (rx_strobe),
		.invert_mask (invert_mask),
		.enable_mask (enable_mask),
		.integrating (integrating),
		.start_pulse (start_pulse),
		.stop_pulse  (stop_pulse)
	);

	pulse_capture capture (
		.intclk      (intclk),
		.rst_n       (rst_n),
		.line_in     (line_in),
		.invert_mask (invert_mask),
		.enable_mask (enable_mask),
		.integrating (integrating),
		.start_pulse (start_pulse),
		.pulses      (pulses),
		.chan_counts (chan_counts)
	);

	// ##################################################
	// correlators

	coincidence_counter #(.CROSS(0), .LAGS(`CORR_LAG_AUTO)) auto_corr (
		.intclk      (intclk),
		.rst_n       (rst_n),
		.pulses      (pulses),
		.integrating (integrating),
		.start_pulse (start_pulse),
		.counts      (auto_counts)
	);

	coincidence_counter #(.CROSS(1), .LAGS(`CORR_LAG_CROSS)) cross_corr (
		.intclk      (intclk),
		.rst_n       (rst_n),
		.pulses      (pulses),
		.integrating (integrating),
		.start_pulse (start_pulse),
		.counts      (cross_counts)
	);

	frame_packer packer (
		.intclk       (intclk),
		.rst_n        (rst_n),
		.stop_pulse   (stop_pulse),
		.chan_counts  (chan_counts),
		.auto_counts  (auto_counts),
		.cross_counts (cross_counts),
		.tx_done      (tx_done),
		.tx_byte      (tx_byte),
		.tx_valid     (tx_valid)
	);

endmodule

//--- hdl/frame_packer.sv
`timescale 1ns/1ps
`include "corr_defs.svh"

module frame_packer (
	input  logic intclk,
	input  logic rst_n,
	input  logic stop_pulse,
	input  corr_frame_pkg::count_t [`CORR_NUM_INPUTS-1:0] chan_counts,
	input  corr_frame_pkg::count_t [`CORR_NUM_AUTO-1:0] auto_counts,
	input  corr_frame_pkg::count_t [`CORR_NUM_CROSS-1:0] cross_counts,
	input  logic tx_done,
	output logic [7:0] tx_byte,
	output logic tx_valid
);
	import corr_frame_pkg::*;

	localparam int N = `CORR_NUM_INPUTS;
	localparam int NA = `CORR_NUM_AUTO;
	localparam int NX = `CORR_NUM_CROSS;
	localparam int NUM_COUNTS = N + NA + NX;
	localparam int BPC = `CORR_RESOLUTION / 8; // bytes per count
	localparam int CW = $clog2(NUM_COUNTS);
	localparam int BW = (BPC > 1) ? $clog2(BPC) : 1;
	localparam logic [7:0] CFG_BYTE = {4'(`CORR_LAG_AUTO), 4'(`CORR_NUM_INPUTS)};

	frame_state_t state;
	logic [CW-1:0] cidx; // count index, header byte index in HEADER
	logic [BW-1:0] bidx; // byte within count, counts down
	logic [7:0] csum;
	count_t snap [NUM_COUNTS];

	// ##################################################
	// snapshot, taken only when idle

	always_ff @(posedge intclk) begin
		if (state == IDLE && stop_pulse) begin
			for (int c = 0; c < N; c++)
				snap[c] <= chan_counts[c];
			for (int a = 0; a < NA; a++)
				snap[N + a] <= auto_counts[a];
			for (int x = 0; x < NX; x++)
				snap[N + NA + x] <= cross_counts[x];
		end
	end

	// ##################################################
	// byte sequencer

	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			cidx <= '0;
			bidx <= '0;
			csum <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (stop_pulse) begin
						state <= HEADER;
						cidx <= '0;
						csum <= '0;
					end
				end
				HEADER: begin
					if (tx_done) begin
						csum <= csum ^ tx_byte;
						if (cidx == CW'(1)) begin
							state <= BODY;
							cidx <= '0;
							bidx <= BW'(BPC-1); // msb first
						end else begin
							cidx <= cidx + 1'b1;
						end
					end
				end
				BODY: begin
					if (tx_done) begin
						csum <= csum ^ tx_byte;
						if (bidx != '0) begin
							bidx <= bidx - 1'b1;
						end else begin
							bidx <= BW'(BPC-1);
							if (cidx == CW'(NUM_COUNTS-1))
								state <= CHECKSUM;
							else
								cidx <= cidx + 1'b1;
						end
					end
				end
				CHECKSUM: begin
					if (tx_done)
						state <= IDLE; // tx_valid drops next cycle
				end
				default: state <= IDLE;
			endcase
		end
	end

	// held stable by the state and index registers until tx_done
	always_comb begin
		case (state)
			HEADER: tx_byte = (cidx == '0) ? `CORR_SYNC_BYTE : CFG_BYTE;
			BODY: tx_byte = snap[cidx][bidx*8 +: 8];
			CHECKSUM: tx_byte = csum;
			default: tx_byte = 8'h00;
		endcase
	end

	assign tx_valid = (state != IDLE);

endmodule

//--- hdl/coincidence_counter.sv
`timescale 1ns/1ps
`include "corr_defs.svh"

module coincidence_counter #(
	parameter int CROSS = 0, // 0 auto, 1 cross
	parameter int LAGS = 1,
	localparam int NUM_OUT = (CROSS != 0) ? `CORR_NUM_BASELINES*(2*LAGS-1)
		: `CORR_NUM_INPUTS*LAGS
) (
	input  logic intclk,
	input  logic rst_n,
	input  corr_cfg_pkg::chan_mask_t pulses,
	input  logic integrating,
	input  logic start_pulse,
	output corr_frame_pkg::count_t [NUM_OUT-1:0] counts
);
	import corr_cfg_pkg::*;
	import corr_frame_pkg::*;

	localparam int N = `CORR_NUM_INPUTS;
	// cross needs LAGS-1 past samples, auto needs LAGS
	localparam int DEPTH = (CROSS != 0 && LAGS > 1) ? LAGS-1 : LAGS;

	chan_mask_t hist [DEPTH]; // hist[k-1] holds pulses from k cycles ago
	logic [NUM_OUT-1:0] hit;

	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			for (int d = 0; d < DEPTH; d++)
				hist[d] <= '0;
		end else begin
			hist[0] <= pulses;
			for (int d = 1; d < DEPTH; d++)
				hist[d] <= hist[d-1];
		end
	end

	// ##################################################
	// coincidence map

	if (CROSS == 0) begin : g_auto
		// channel-major, lag 1 first
		for (genvar c = 0; c < N; c++) begin : g_chan
			for (genvar k = 1; k <= LAGS; k++) begin : g_lag
				assign hit[c*LAGS + k-1] = pulses[c] & hist[k-1][c];
			end
		end
	end else begin : g_cross
		for (genvar i = 0; i < N; i++) begin : g_first
			for (genvar j = i+1; j < N; j++) begin : g_second
				localparam int PAIR = i*N - i*(i+1)/2 + (j-i-1);
				for (genvar l = 0; l < 2*LAGS-1; l++) begin : g_lag
					localparam int LAG = l - (LAGS-1);
					localparam int IDX = PAIR*(2*LAGS-1) + l;
					if (LAG == 0) begin : g_zero
						assign hit[IDX] = pulses[i] & pulses[j];
					end else if (LAG > 0) begin : g_pos
						assign hit[IDX] = pulses[i] & hist[LAG-1][j]; // j earlier
					end else begin : g_neg
						assign hit[IDX] = pulses[j] & hist[-LAG-1][i]; // i earlier
					end
				end
			end
		end
	end

	// ##################################################
	// saturating counters

	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			counts <= '0;
		end else if (start_pulse) begin
			counts <= '0;
		end else if (integrating) begin
			for (int n = 0; n < NUM_OUT; n++) begin
				if (hit[n])
					counts[n] <= sat_inc(counts[n]);
			end
		end
	end

endmodule

//--- hdl/pulse_capture.sv
`timescale 1ns/1ps
`include "corr_defs.svh"

module pulse_capture (
	input  logic intclk,
	input  logic rst_n,
	input  logic [`CORR_NUM_INPUTS-1:0] line_in,
	input  corr_cfg_pkg::chan_mask_t invert_mask,
	input  corr_cfg_pkg::chan_mask_t enable_mask,
	input  logic integrating,
	input  logic start_pulse,
	output corr_cfg_pkg::chan_mask_t pulses,
	output corr_frame_pkg::count_t [`CORR_NUM_INPUTS-1:0] chan_counts
);
	import corr_cfg_pkg::*;
	import corr_frame_pkg::*;

	chan_mask_t sync_q1;
	chan_mask_t sync_q2;
	chan_mask_t level; // synchronized line after inversion
	chan_mask_t level_q;

	assign level = sync_q2 ^ invert_mask;

	// ##################################################
	// synchronizer and edge detect

	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			sync_q1 <= '0;
			sync_q2 <= '0;
			level_q <= '0;
			pulses <= '0;
		end else begin
			sync_q1 <= line_in;
			sync_q2 <= sync_q1;
			level_q <= level;
			pulses <= level & ~level_q & enable_mask; // rising edges only
		end
	end

	// ##################################################
	// per-channel counts

	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			chan_counts <= '0;
		end else if (start_pulse) begin
			chan_counts <= '0; // new window
		end else if (integrating) begin
			for (int c = 0; c < `CORR_NUM_INPUTS; c++) begin
				if (pulses[c])
					chan_counts[c] <= sat_inc(chan_counts[c]);
			end
		end
	end

endmodule

//--- hdl/cmd_parser.sv
`timescale 1ns/1ps
`include "corr_defs.svh"

module cmd_parser (
	input  logic intclk,
	input  logic rst_n,
	input  logic [7:0] rx_byte,
	input  logic rx_strobe,
	output corr_cfg_pkg::chan_mask_t invert_mask,
	output corr_cfg_pkg::chan_mask_t enable_mask,
	output logic integrating,
	output logic start_pulse,
	output logic stop_pulse
);
	import corr_cfg_pkg::*;

	cmd_op_t op;
	logic [3:0] arg;

	assign op = cmd_op_t'(rx_byte[7:4]);
	assign arg = rx_byte[3:0];

	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			invert_mask <= '0;
			enable_mask <= '0;
			integrating <= 1'b0;
			start_pulse <= 1'b0;
			stop_pulse <= 1'b0;
		end else begin
			start_pulse <= 1'b0; // pulses last one cycle
			stop_pulse <= 1'b0;
			if (rx_strobe) begin
				case (op)
					OP_INVERT: invert_mask <= chan_mask_t'(arg);
					OP_ENABLE: enable_mask <= chan_mask_t'(arg);
					OP_START: begin
						// a repeated START is a no-op
						if (!integrating) begin
							integrating <= 1'b1;
							start_pulse <= 1'b1;
						end
					end
					OP_STOP: begin
						if (integrating) begin
							integrating <= 1'b0;
							stop_pulse <= 1'b1;
						end
					end
					default: ; // unknown opcode dropped
				endcase
			end
		end
	end

endmodule

//--- hdl/corr_frame_pkg.sv
`include "corr_defs.svh"

package corr_frame_pkg;

	typedef logic [`CORR_RESOLUTION-1:0] count_t; // sticks at all ones

	typedef enum logic [1:0] {
		IDLE,
		HEADER, // sync and config bytes
		BODY, // counts, msb first
		CHECKSUM
	} frame_state_t;

	// saturating increment shared by all counters
	function automatic count_t sat_inc(input count_t c);
		return (c == '1) ? c : c + 1'b1;
	endfunction

endpackage

//--- hdl/corr_cfg_pkg.sv
`include "corr_defs.svh"

package corr_cfg_pkg;

	// upper nibble of a command byte, lower nibble is the argument
	typedef enum logic [3:0] {
		OP_INVERT = 4'd1, // load inversion mask
		OP_ENABLE = 4'd2, // load enable mask
		OP_START  = 4'd3, // open window
		OP_STOP   = 4'd4  // close window, send frame
	} cmd_op_t;

	// one bit per input line
	typedef logic [`CORR_NUM_INPUTS-1:0] chan_mask_t;

endpackage

//--- hdl/corr_defs.svh
`ifndef CORR_DEFS_SVH
`define CORR_DEFS_SVH

// ##################################################
// instrument geometry

`define CORR_NUM_INPUTS 4 // input lines
`define CORR_RESOLUTION 16 // bits per counter, multiple of 8
`define CORR_LAG_AUTO 2 // auto lags 1..LAG_AUTO
`define CORR_LAG_CROSS 2 // cross lags -(LAG_CROSS-1)..+(LAG_CROSS-1)

`define CORR_NUM_BASELINES (`CORR_NUM_INPUTS*(`CORR_NUM_INPUTS-1)/2)
`define CORR_NUM_AUTO (`CORR_NUM_INPUTS*`CORR_LAG_AUTO)
`define CORR_NUM_CROSS (`CORR_NUM_BASELINES*(2*`CORR_LAG_CROSS-1))

// ##################################################
// frame

`define CORR_SYNC_BYTE 8'hA5

`endif
